/* hw/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// width of data words, addresses and instructions
`define WORD_SIZE 16

// general registers r0 to r3
`define REG_COUNT 4

// the core starts fetching here after reset
`define RESET_VECTOR 16'h0000

// JAL and JRL leave the return address in this register
`define LINK_REG 2

`endif

/* hw/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	typedef enum logic [3:0] {
		OP_BNE = 4'd0,
		OP_BEQ = 4'd1,
		OP_BGZ = 4'd2,
		OP_BLZ = 4'd3,
		OP_ADI = 4'd4,
		OP_ORI = 4'd5,
		OP_LHI = 4'd6,
		OP_LWD = 4'd7,
		OP_SWD = 4'd8,
		OP_JMP = 4'd9,
		OP_JAL = 4'd10,
		OP_RTYPE = 4'd15 // the function field selects the operation
	} opcodeT;

	typedef enum logic [5:0] {
		FN_ADD = 6'd0,
		FN_SUB = 6'd1,
		FN_AND = 6'd2,
		FN_ORR = 6'd3,
		FN_NOT = 6'd4,
		FN_TCP = 6'd5,
		FN_SHL = 6'd6,
		FN_SHR = 6'd7,
		FN_JPR = 6'd25,
		FN_JRL = 6'd26,
		FN_HLT = 6'd29
	} funcT;

	typedef struct packed {
		opcodeT opcode;
		logic [1:0] rs;
		logic [1:0] rt;
		logic [1:0] rd;
		funcT func;
	} rTypeT;

	typedef struct packed {
		logic [1:0] rs;
		logic [1:0] rt;
		logic [7:0] imm;
	} immFieldsT;

	// jumps read the low twelve bits as one target
	typedef union packed {
		immFieldsT f;
		logic [11:0] target;
	} iBodyT;

	typedef struct packed {
		opcodeT opcode;
		iBodyT body;
	} iTypeT;

	typedef union packed {
		rTypeT rType;
		iTypeT iType;
	} instrT;

	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_ORR = 4'd3,
		ALU_NOT = 4'd4,
		ALU_TCP = 4'd5,
		ALU_SHL = 4'd6,
		ALU_SHR = 4'd7,
		ALU_ORI = 4'd8, // or with the zero-extended low byte of b
		ALU_LHI = 4'd9
	} aluOpT;

	typedef enum logic [2:0] {
		FETCH = 3'd0,
		DECODE = 3'd1,
		MEMREAD = 3'd2,
		MEMWRITE = 3'd3,
		WRITEBACK = 3'd4,
		HALT = 3'd5
	} ctrlStateT;

	// next-PC select codes shared by the control unit and the PC unit
	localparam logic [1:0] PC_SEQ = 2'd0;
	localparam logic [1:0] PC_BRANCH = 2'd1;
	localparam logic [1:0] PC_TARGET = 2'd2;
	localparam logic [1:0] PC_REG = 2'd3;

endpackage

`default_nettype wire

/* hw/controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnit import cpu_pkg::*; (
	input logic clk,
	input logic reset_n,
	input instrT instr,
	input logic busDone,
	input logic zero,
	input logic positive,
	input logic negative,
	output logic fetchReq,
	output logic dataReadReq,
	output logic dataWriteReq,
	output logic regWrite,
	output logic memToReg,
	output logic linkWrite,
	output logic aluSrcImm,
	output aluOpT aluOp,
	output logic pcLoad,
	output logic [1:0] pcSrc,
	output logic halted
);

	ctrlStateT state;
	ctrlStateT nextState;
	logic taken;

	always_ff @(posedge clk) begin
		if (reset_n) begin
			state <= FETCH;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		case (instr.iType.opcode)
			OP_BNE: taken = !zero;
			OP_BEQ: taken = zero;
			OP_BGZ: taken = positive; // sign of rs alone
			OP_BLZ: taken = negative;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		fetchReq = 1'b0;
		dataReadReq = 1'b0;
		dataWriteReq = 1'b0;
		regWrite = 1'b0;
		memToReg = 1'b0;
		linkWrite = 1'b0;
		aluSrcImm = 1'b0;
		aluOp = ALU_ADD;
		pcLoad = 1'b0;
		pcSrc = PC_SEQ;
		nextState = state;
		case (state)
			FETCH: begin
				fetchReq = 1'b1;
				if (busDone) nextState = DECODE;
			end
			DECODE: begin
				nextState = FETCH;
				pcLoad = 1'b1;
				case (instr.iType.opcode)
					OP_RTYPE: begin
						regWrite = 1'b1;
						case (instr.rType.func)
							FN_ADD: aluOp = ALU_ADD;
							FN_SUB: aluOp = ALU_SUB;
							FN_AND: aluOp = ALU_AND;
							FN_ORR: aluOp = ALU_ORR;
							FN_NOT: aluOp = ALU_NOT;
							FN_TCP: aluOp = ALU_TCP;
							FN_SHL: aluOp = ALU_SHL;
							FN_SHR: aluOp = ALU_SHR;
							FN_JPR: begin
								regWrite = 1'b0;
								pcSrc = PC_REG;
							end
							FN_JRL: begin
								linkWrite = 1'b1;
								pcSrc = PC_REG;
							end
							FN_HLT: begin
								regWrite = 1'b0;
								nextState = HALT;
							end
							default: regWrite = 1'b0; // unknown functions retire as no-ops
						endcase
					end
					OP_ADI, OP_ORI, OP_LHI: begin
						regWrite = 1'b1;
						aluSrcImm = 1'b1;
						if (instr.iType.opcode == OP_ORI) aluOp = ALU_ORI;
						else if (instr.iType.opcode == OP_LHI) aluOp = ALU_LHI;
					end
					OP_LWD, OP_SWD: begin
						pcLoad = 1'b0; // PC moves once the memory access is over
						aluSrcImm = 1'b1;
						nextState = (instr.iType.opcode == OP_LWD) ? MEMREAD : MEMWRITE;
					end
					OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ: begin
						aluOp = ALU_SUB;
						pcSrc = taken ? PC_BRANCH : PC_SEQ;
					end
					OP_JMP: pcSrc = PC_TARGET;
					OP_JAL: begin
						regWrite = 1'b1;
						linkWrite = 1'b1;
						pcSrc = PC_TARGET;
					end
					default: ;
				endcase
			end
			MEMREAD: begin
				aluSrcImm = 1'b1; // keeps rs plus offset on the data address
				dataReadReq = 1'b1;
				if (busDone) nextState = WRITEBACK;
			end
			MEMWRITE: begin
				aluSrcImm = 1'b1;
				dataWriteReq = 1'b1;
				if (busDone) begin
					pcLoad = 1'b1;
					nextState = FETCH;
				end
			end
			WRITEBACK: begin
				regWrite = 1'b1;
				memToReg = 1'b1;
				pcLoad = 1'b1;
				nextState = FETCH;
			end
			default: nextState = HALT; // only reset leaves the halt state
		endcase
	end

	assign halted = (state == HALT);

endmodule

`default_nettype wire

/* hw/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module registerFile (
	input logic clk,
	input logic reset_n,
	input logic [$clog2(`REG_COUNT)-1:0] readA,
	input logic [$clog2(`REG_COUNT)-1:0] readB,
	input logic [$clog2(`REG_COUNT)-1:0] writeAddr,
	input logic [`WORD_SIZE-1:0] writeData,
	input logic writeEn,
	output logic [`WORD_SIZE-1:0] dataA,
	output logic [`WORD_SIZE-1:0] dataB
);

	logic [`WORD_SIZE-1:0] regs [`REG_COUNT];

	always_ff @(posedge clk) begin
		if (reset_n) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeAddr] <= writeData;
		end
	end

	// reads see the old value in the cycle of a write
	assign dataA = regs[readA];
	assign dataB = regs[readB];

endmodule

`default_nettype wire

/* hw/alu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module alu import cpu_pkg::*; (
	input logic [`WORD_SIZE-1:0] a,
	input logic [`WORD_SIZE-1:0] b,
	input aluOpT op,
	output logic [`WORD_SIZE-1:0] result,
	output logic zero,
	output logic positive,
	output logic negative
);

	logic [`WORD_SIZE-1:0] diff;

	assign diff = a - b;

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = diff;
			ALU_AND: result = a & b;
			ALU_ORR: result = a | b;
			ALU_NOT: result = ~a;
			ALU_TCP: result = ~a + 1'b1;
			ALU_SHL: result = {a[`WORD_SIZE-2:0], 1'b0};
			ALU_SHR: result = {a[`WORD_SIZE-1], a[`WORD_SIZE-1:1]}; // arithmetic shift
			ALU_ORI: result = a | {8'h00, b[7:0]};
			ALU_LHI: result = {b[7:0], 8'h00};
			default: result = '0;
		endcase
	end

	// equality comes from the difference, sign tests look at a only
	assign zero = (diff == '0);
	assign negative = a[`WORD_SIZE-1];
	assign positive = !a[`WORD_SIZE-1] && (a != '0);

endmodule

`default_nettype wire

/* hw/pcUnit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module pcUnit import cpu_pkg::*; (
	input logic clk,
	input logic reset_n,
	input logic load,
	input logic [1:0] src,
	input logic [7:0] offset,
	input logic [11:0] target,
	input logic [`WORD_SIZE-1:0] regTarget,
	output logic [`WORD_SIZE-1:0] pc,
	output logic [`WORD_SIZE-1:0] pcPlusOne
);

	logic [`WORD_SIZE-1:0] nextPc;

	assign pcPlusOne = pc + 1'b1;

	always_comb begin
		case (src)
			PC_BRANCH: nextPc = pcPlusOne + {{(`WORD_SIZE-8){offset[7]}}, offset};
			PC_TARGET: nextPc = {pc[`WORD_SIZE-1:12], target}; // stays in the current 4K page
			PC_REG: nextPc = regTarget;
			default: nextPc = pcPlusOne;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_n) begin
			pc <= `RESET_VECTOR;
		end else if (load) begin
			pc <= nextPc;
		end
	end

endmodule

`default_nettype wire

/* hw/memoryInterface.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module memoryInterface import cpu_pkg::*; (
	input logic clk,
	input logic reset_n,
	input logic fetchReq,
	input logic dataReadReq,
	input logic dataWriteReq,
	input logic [`WORD_SIZE-1:0] fetchAddr,
	input logic [`WORD_SIZE-1:0] dataAddr,
	input logic [`WORD_SIZE-1:0] storeData,
	input logic inputReady,
	input logic ackOutput,
	output logic readM,
	output logic writeM,
	output logic [`WORD_SIZE-1:0] address,
	output logic busDone,
	output instrT instrOut,
	output logic [`WORD_SIZE-1:0] loadData,
	inout wire [`WORD_SIZE-1:0] data
);

	logic isFetch;
	logic [`WORD_SIZE-1:0] storeReg;

	always_ff @(posedge clk) begin
		if (reset_n) begin
			readM <= 1'b0;
			writeM <= 1'b0;
			busDone <= 1'b0;
			isFetch <= 1'b0;
		end else begin
			busDone <= 1'b0;
			if (readM) begin
				if (inputReady) begin
					readM <= 1'b0;
					busDone <= 1'b1;
				end
			end else if (writeM) begin
				if (ackOutput) begin
					writeM <= 1'b0;
					busDone <= 1'b1;
				end
			end else if (!busDone) begin // the requester still holds its request in the done cycle
				if (fetchReq) begin
					readM <= 1'b1;
					isFetch <= 1'b1;
				end else if (dataReadReq) begin
					readM <= 1'b1;
					isFetch <= 1'b0;
				end else if (dataWriteReq) begin
					writeM <= 1'b1;
					isFetch <= 1'b0;
				end
			end
		end
	end

	// address, store word and returned words only move at the edges of a transfer
	always_ff @(posedge clk) begin
		if (!readM && !writeM && !busDone) begin
			address <= fetchReq ? fetchAddr : dataAddr;
			storeReg <= storeData;
		end
		if (readM && inputReady) begin
			if (isFetch) instrOut <= data;
			else loadData <= data;
		end
	end

	assign data = writeM ? storeReg : 'z;

endmodule

`default_nettype wire

/* hw/cpu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module cpu import cpu_pkg::*; (
	output logic readM,
	output logic writeM,
	output logic [`WORD_SIZE-1:0] address,
	inout wire [`WORD_SIZE-1:0] data,
	input logic ackOutput,
	input logic inputReady,
	input logic reset_n,
	input logic clk,
	output logic halted
);

	instrT instr;
	aluOpT aluOp;
	logic fetchReq, dataReadReq, dataWriteReq, busDone;
	logic regWrite, memToReg, linkWrite, aluSrcImm, pcLoad;
	logic [1:0] pcSrc;
	logic zero, positive, negative;
	logic [1:0] writeAddr;
	logic [`WORD_SIZE-1:0] dataA, dataB, aluB, immExt, aluResult;
	logic [`WORD_SIZE-1:0] writeData, loadData, pc, pcPlusOne;

	assign immExt = {{(`WORD_SIZE-8){instr.iType.body.f.imm[7]}}, instr.iType.body.f.imm};
	assign aluB = aluSrcImm ? immExt : dataB;
	assign writeData = memToReg ? loadData : (linkWrite ? pcPlusOne : aluResult);
	assign writeAddr = linkWrite ? 2'(`LINK_REG)
		: ((instr.rType.opcode == OP_RTYPE) ? instr.rType.rd : instr.rType.rt);

	controlUnit control (
		.clk(clk), .reset_n(reset_n), .instr(instr), .busDone(busDone),
		.zero(zero), .positive(positive), .negative(negative),
		.fetchReq(fetchReq), .dataReadReq(dataReadReq), .dataWriteReq(dataWriteReq),
		.regWrite(regWrite), .memToReg(memToReg), .linkWrite(linkWrite),
		.aluSrcImm(aluSrcImm), .aluOp(aluOp), .pcLoad(pcLoad), .pcSrc(pcSrc),
		.halted(halted)
	);

	registerFile regs (
		.clk(clk), .reset_n(reset_n),
		.readA(instr.rType.rs), .readB(instr.rType.rt),
		.writeAddr(writeAddr), .writeData(writeData), .writeEn(regWrite),
		.dataA(dataA), .dataB(dataB)
	);

	alu datapathAlu (
		.a(dataA), .b(aluB), .op(aluOp), .result(aluResult),
		.zero(zero), .positive(positive), .negative(negative)
	);

	pcUnit programCounter (
		.clk(clk), .reset_n(reset_n), .load(pcLoad), .src(pcSrc),
		.offset(instr.iType.body.f.imm), .target(instr.iType.body.target),
		.regTarget(dataA), .pc(pc), .pcPlusOne(pcPlusOne)
	);

	// loads and stores address rs plus offset through the ALU
	memoryInterface bus (
		.clk(clk), .reset_n(reset_n),
		.fetchReq(fetchReq), .dataReadReq(dataReadReq), .dataWriteReq(dataWriteReq),
		.fetchAddr(pc), .dataAddr(aluResult), .storeData(dataB),
		.inputReady(inputReady), .ackOutput(ackOutput),
		.readM(readM), .writeM(writeM), .address(address), .busDone(busDone),
		.instrOut(instr), .loadData(loadData), .data(data)
	);

endmodule

`default_nettype wire

/* test/cpu_assertions.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module cpuAssertions (
	input logic clk,
	input logic reset_n,
	input logic readM,
	input logic writeM,
	input logic [`WORD_SIZE-1:0] address,
	input wire [`WORD_SIZE-1:0] data,
	input logic inputReady,
	input logic ackOutput,
	input logic halted
);

	int failCount = 0; // number of failed bus checks so far

	oneRequest: assert property (@(posedge clk) disable iff (reset_n) !(readM && writeM))
		else begin
			failCount++;
			$error("readM and writeM were high in the same cycle");
		end

	// an unacknowledged read keeps its request and address
	readHeld: assert property (@(posedge clk) disable iff (reset_n)
		readM && !inputReady |=> readM && $stable(address))
		else begin
			failCount++;
			$error("read request or address changed before inputReady");
		end

	writeHeld: assert property (@(posedge clk) disable iff (reset_n)
		writeM && !ackOutput |=> writeM && $stable(address) && $stable(data))
		else begin
			failCount++;
			$error("write request, address or data changed before ackOutput");
		end

	readDrop: assert property (@(posedge clk) disable iff (reset_n)
		readM && inputReady |=> !readM)
		else begin
			failCount++;
			$error("readM still high one cycle after inputReady");
		end

	writeDrop: assert property (@(posedge clk) disable iff (reset_n)
		writeM && ackOutput |=> !writeM)
		else begin
			failCount++;
			$error("writeM still high one cycle after ackOutput");
		end

	haltQuiet: assert property (@(posedge clk) disable iff (reset_n)
		halted |-> !readM && !writeM)
		else begin
			failCount++;
			$error("bus request while halted");
		end

endmodule

`default_nettype wire

/* test/cpuTb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module cpuTb import cpu_pkg::*; ();

	localparam logic [15:0] OPERAND_A = 16'h5A3C;
	localparam logic [15:0] OPERAND_B = 16'h8F71;
	localparam int DATA_BASE = 'h80;
	localparam int LOAD_OFFSET = 'h40;
	localparam int CYCLE_LIMIT = 3000; // about four times the slowest run of the program
	localparam int HALT_WATCH = 40;

	logic clk;
	logic reset_n;
	logic inputReady;
	logic ackOutput;
	logic readM;
	logic writeM;
	logic halted;
	logic [15:0] address;
	wire [15:0] data;

	logic [15:0] mem [256];
	logic [15:0] expected [256]; // memory image the program must leave behind
	logic [15:0] readWord;
	logic readDrive;
	logic pending;
	logic firstFetchSeen;
	logic [31:0] rngState;
	int waitLeft;
	int asmPc;
	int errorCount;
	int cycleCount;

	assign data = readDrive ? readWord : 'z;

	cpu DUT (
		.readM(readM), .writeM(writeM), .address(address), .data(data),
		.ackOutput(ackOutput), .inputReady(inputReady), .reset_n(reset_n), .clk(clk),
		.halted(halted)
	);

	bind cpu cpuAssertions busChecks (
		.clk(clk), .reset_n(reset_n), .readM(readM), .writeM(writeM), .address(address),
		.data(data), .inputReady(inputReady), .ackOutput(ackOutput), .halted(halted)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [15:0] rForm(funcT fn, logic [1:0] rs, logic [1:0] rt, logic [1:0] rd);
		return {OP_RTYPE, rs, rt, rd, fn};
	endfunction

	function automatic logic [15:0] iForm(opcodeT op, logic [1:0] rs, logic [1:0] rt, logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [15:0] jForm(opcodeT op, int target);
		return {op, 12'(target)};
	endfunction

	// equality branches compare rs with rt and sign branches look at rs alone
	function automatic logic branchTaken(opcodeT op, logic [15:0] rsVal, logic [15:0] rtVal);
		case (op)
			OP_BEQ: return rsVal == rtVal;
			OP_BNE: return rsVal != rtVal;
			OP_BGZ: return $signed(rsVal) > 0;
			default: return $signed(rsVal) < 0;
		endcase
	endfunction

	task automatic emit(input logic [15:0] word);
		mem[asmPc] = word;
		expected[asmPc] = word;
		asmPc++;
	endtask

	// the result lands in r2 and is stored to its slot of the data area
	task automatic aluCase(input logic [15:0] instr, input int slot, input logic [15:0] result);
		emit(instr);
		emit(iForm(OP_SWD, 2'd3, 2'd2, 8'(slot)));
		expected[DATA_BASE + slot] = result;
	endtask

	task automatic branchCase(input opcodeT op, input logic [1:0] rs, input logic [1:0] rt,
		input int slot);
		logic [15:0] rsVal;
		logic [15:0] rtVal;
		rsVal = (rs == 2'd0) ? OPERAND_A : OPERAND_B;
		rtVal = (rt == 2'd0) ? OPERAND_A : OPERAND_B;
		emit(iForm(op, rs, rt, 8'd2));
		emit(iForm(OP_SWD, 2'd3, 2'd0, 8'(slot))); // fall-through marker
		emit(jForm(OP_JMP, asmPc + 2));
		emit(iForm(OP_SWD, 2'd3, 2'd1, 8'(slot + 1))); // taken marker
		if (branchTaken(op, rsVal, rtVal)) expected[DATA_BASE + slot + 1] = OPERAND_B;
		else expected[DATA_BASE + slot] = OPERAND_A;
	endtask

	task automatic loadProgram();
		int callAddr;
		int jrlAddr;
		for (int i = 0; i < 256; i++) begin
			mem[i] = 16'(i * 'h0101) ^ 16'hC3A5;
			expected[i] = mem[i];
		end
		mem[DATA_BASE + LOAD_OFFSET] = 16'hBEEF;
		expected[DATA_BASE + LOAD_OFFSET] = 16'hBEEF;
		asmPc = 0;
		emit(iForm(OP_LHI, 2'd0, 2'd3, 8'h00));
		emit(iForm(OP_ORI, 2'd3, 2'd3, 8'(DATA_BASE))); // r3 is the data base
		emit(iForm(OP_LHI, 2'd0, 2'd0, OPERAND_A[15:8]));
		emit(iForm(OP_ORI, 2'd0, 2'd0, OPERAND_A[7:0]));
		emit(iForm(OP_LHI, 2'd0, 2'd1, OPERAND_B[15:8]));
		emit(iForm(OP_ORI, 2'd1, 2'd1, OPERAND_B[7:0]));
		aluCase(rForm(FN_ADD, 2'd0, 2'd1, 2'd2), 0, OPERAND_A + OPERAND_B);
		aluCase(rForm(FN_SUB, 2'd0, 2'd1, 2'd2), 1, OPERAND_A - OPERAND_B);
		aluCase(rForm(FN_AND, 2'd0, 2'd1, 2'd2), 2, OPERAND_A & OPERAND_B);
		aluCase(rForm(FN_ORR, 2'd0, 2'd1, 2'd2), 3, OPERAND_A | OPERAND_B);
		aluCase(rForm(FN_NOT, 2'd0, 2'd0, 2'd2), 4, ~OPERAND_A);
		aluCase(rForm(FN_TCP, 2'd0, 2'd0, 2'd2), 5, 16'h0000 - OPERAND_A);
		aluCase(rForm(FN_SHL, 2'd0, 2'd0, 2'd2), 6, OPERAND_A << 1);
		// a negative operand shows that the sign bit is kept
		aluCase(rForm(FN_SHR, 2'd1, 2'd1, 2'd2), 7, {1'b1, OPERAND_B[15:1]});
		aluCase(iForm(OP_ADI, 2'd0, 2'd2, 8'hFD), 8, OPERAND_A - 16'd3); // immediate is -3
		aluCase(iForm(OP_ORI, 2'd1, 2'd2, 8'hC5), 9, OPERAND_B | 16'h00C5);
		aluCase(iForm(OP_LHI, 2'd0, 2'd2, 8'hA7), 10, 16'hA700);
		aluCase(iForm(OP_LWD, 2'd3, 2'd2, 8'(LOAD_OFFSET)), 11, 16'hBEEF);
		branchCase(OP_BEQ, 2'd0, 2'd0, 12);
		branchCase(OP_BEQ, 2'd0, 2'd1, 14);
		branchCase(OP_BNE, 2'd0, 2'd1, 16);
		branchCase(OP_BNE, 2'd0, 2'd0, 18);
		branchCase(OP_BGZ, 2'd0, 2'd0, 20);
		branchCase(OP_BGZ, 2'd1, 2'd0, 22);
		branchCase(OP_BLZ, 2'd1, 2'd0, 24);
		branchCase(OP_BLZ, 2'd0, 2'd0, 26);
		callAddr = asmPc;
		emit(jForm(OP_JAL, callAddr + 3));
		emit(iForm(OP_SWD, 2'd3, 2'd2, 8'd28)); // subroutine returns here
		emit(jForm(OP_JMP, callAddr + 5));
		emit(iForm(OP_SWD, 2'd3, 2'd0, 8'd29));
		emit(rForm(FN_JPR, 2'd2, 2'd0, 2'd0));
		expected[DATA_BASE + 28] = 16'(callAddr + 1);
		expected[DATA_BASE + 29] = OPERAND_A;
		jrlAddr = asmPc + 2;
		emit(iForm(OP_LHI, 2'd0, 2'd1, 8'h00));
		emit(iForm(OP_ORI, 2'd1, 2'd1, 8'(jrlAddr + 3)));
		emit(rForm(FN_JRL, 2'd1, 2'd0, 2'd0));
		emit(iForm(OP_SWD, 2'd3, 2'd2, 8'd30));
		emit(rForm(FN_HLT, 2'd0, 2'd0, 2'd0));
		emit(iForm(OP_SWD, 2'd3, 2'd0, 8'd31));
		emit(rForm(FN_JPR, 2'd2, 2'd0, 2'd0));
		expected[DATA_BASE + 30] = 16'(jrlAddr + 1);
		expected[DATA_BASE + 31] = OPERAND_A;
	endtask

	task automatic checkMemory();
		for (int i = 0; i < 256; i++) begin
			assert (mem[i] === expected[i]) else begin
				errorCount++;
				$display("error at %0t: word %h holds %h, expected %h", $time, 8'(i), mem[i],
					expected[i]);
			end
		end
	endtask

	task automatic reportAndFinish();
		int assertFails;
		assertFails = DUT.busChecks.failCount;
		$display("errors: %0d, assertion failures: %0d", errorCount, assertFails);
		if (errorCount == 0 && assertFails == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// memory model answering every request after 0 to 3 wait cycles
	initial begin
		inputReady = 1'b0;
		ackOutput = 1'b0;
		readDrive = 1'b0;
		readWord = '0;
		pending = 1'b0;
		firstFetchSeen = 1'b0;
		waitLeft = 0;
		rngState = 32'd81;
		forever begin
			@(posedge clk);
			#2;
			if (reset_n) begin
				assert (!readM && !writeM) else begin
					errorCount++;
					$display("a bus request was raised while reset was held, at %0t", $time);
				end
			end else if (readM && !firstFetchSeen) begin
				firstFetchSeen = 1'b1;
				assert (address == `RESET_VECTOR) else begin
					errorCount++;
					$display("error at %0t: first fetch from %h, expected %h", $time, address,
						`RESET_VECTOR);
				end
			end
			if (halted) begin
				assert (!readM && !writeM) else begin
					errorCount++;
					$display("the bus was requested after HLT, at %0t", $time);
				end
			end
			if (inputReady || ackOutput) begin
				inputReady = 1'b0; // the DUT took the word at the last edge
				ackOutput = 1'b0;
				readDrive = 1'b0;
				pending = 1'b0;
			end else if (readM || writeM) begin
				if (!pending) begin
					pending = 1'b1;
					rngState = xorshift(rngState);
					waitLeft = int'(rngState[1:0]);
				end
				if (waitLeft > 0) begin
					waitLeft--;
				end else if (readM) begin
					readWord = mem[address[7:0]];
					readDrive = 1'b1;
					inputReady = 1'b1;
				end else begin
					mem[address[7:0]] = data;
					ackOutput = 1'b1;
				end
			end
		end
	end

	initial begin
		errorCount = 0;
		reset_n = 1'b1;
		loadProgram();
		repeat (8) @(posedge clk);
		#2;
		reset_n = 1'b0;
		while (!halted) @(posedge clk);
		repeat (HALT_WATCH) @(posedge clk); // the bus has to stay quiet after HLT
		checkMemory();
		reportAndFinish();
	end

	initial begin
		cycleCount = 0;
		while (cycleCount < CYCLE_LIMIT) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout: the program did not finish within %0d cycles", CYCLE_LIMIT);
		errorCount++;
		reportAndFinish();
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+hw
hw/cpu_pkg.sv
hw/controlUnit.sv
hw/registerFile.sv
hw/alu.sv
hw/pcUnit.sv
hw/memoryInterface.sv
hw/cpu.sv
test/cpu_assertions.sv
test/cpuTb.sv

/* Bender.yml */
package:
  name: cpu16

export_include_dirs:
  - hw

sources:
  - files:
      - hw/cpu_pkg.sv
      - hw/controlUnit.sv
      - hw/registerFile.sv
      - hw/alu.sv
      - hw/pcUnit.sv
      - hw/memoryInterface.sv
      - hw/cpu.sv
  - target: test
    files:
      - test/cpu_assertions.sv
      - test/cpuTb.sv
